//--- ooo_pkg.sv
////////////////////////////////////////
// machine widths of the core
// data word, rs tag, history index,
// branch result and the null tag
////////////////////////////////////////

package ooo_pkg;

   localparam int WORD_BITS    = 64;
   localparam int TAG_BITS     = 5;
   localparam int HISTORY_BITS = 8;

   // data or address word
   typedef logic [WORD_BITS-1:0] word_t;

   // reservation station tag
   typedef logic [TAG_BITS-1:0] rs_tag_t;

   // pattern history index
   typedef logic [HISTORY_BITS-1:0] pht_index_t;

   // bit 1 marks a branch and bit 0 holds the actual outcome
   typedef logic [1:0] br_result_t;

   localparam int BR_RESULT_IS_BRANCH = 1;
   localparam int BR_RESULT_TAKEN     = 0;

   // marks an empty cdb slot
   localparam rs_tag_t RSTAG_NULL = '1;

endpackage

//--- isa_pkg.sv
////////////////////////////////////////
// instruction set encodings
// alu operation codes, branch condition
// codes, instruction size
////////////////////////////////////////

package isa_pkg;

   ////////////////////////////////////////
   // integer operations
   ////////////////////////////////////////

   localparam int ALU_OP_BITS = 3;
   typedef logic [ALU_OP_BITS-1:0] alu_op_t;

   localparam alu_op_t ALU_ADD = 3'd0;
   localparam alu_op_t ALU_SUB = 3'd1;
   localparam alu_op_t ALU_AND = 3'd2;
   localparam alu_op_t ALU_OR  = 3'd3;
   localparam alu_op_t ALU_XOR = 3'd4;
   // shift amount is the low bits of operand b
   localparam alu_op_t ALU_SLL = 3'd5;
   localparam alu_op_t ALU_SRL = 3'd6;
   // signed compare giving 1 or 0
   localparam alu_op_t ALU_SLT = 3'd7;

   localparam int SHIFT_BITS = 6;

   ////////////////////////////////////////
   // branch conditions
   ////////////////////////////////////////

   localparam int BR_COND_BITS = 2;
   typedef logic [BR_COND_BITS-1:0] br_cond_t;

   localparam br_cond_t BR_EQ     = 2'd0;
   localparam br_cond_t BR_NE     = 2'd1;
   localparam br_cond_t BR_LT     = 2'd2;
   localparam br_cond_t BR_ALWAYS = 2'd3;

   // fall-through step
   localparam int INSN_BYTES = 4;

endpackage

//--- alu_lane.sv
////////////////////////////////////////
// integer execution lane
// alu datapath and execute/complete
// output register
////////////////////////////////////////

`timescale 1ns/100ps

module alu_lane
   import ooo_pkg::*;
   import isa_pkg::*;
(
   input  logic    clock,
   input  logic    rst_n,

   // issue side
   input  logic    alu_issue,
   input  rs_tag_t alu_tag,
   input  alu_op_t alu_op,
   input  word_t   alu_a,
   input  word_t   alu_b,
   input  word_t   alu_npc,

   // to complete stage
   output rs_tag_t ex_cm_tag,
   output word_t   ex_cm_result,
   output word_t   ex_cm_npc,
   output logic    ex_cm_valid
);

   word_t                 alu_result;
   logic [SHIFT_BITS-1:0] shamt;

   assign shamt = alu_b[SHIFT_BITS-1:0];

   ////////////////////////////////////////
   // execute
   ////////////////////////////////////////

   always_comb begin
      case (alu_op)
         ALU_ADD: alu_result = alu_a + alu_b;
         ALU_SUB: alu_result = alu_a - alu_b;
         ALU_AND: alu_result = alu_a & alu_b;
         ALU_OR:  alu_result = alu_a | alu_b;
         ALU_XOR: alu_result = alu_a ^ alu_b;
         ALU_SLL: alu_result = alu_a << shamt;
         ALU_SRL: alu_result = alu_a >> shamt;
         // zero extended compare bit
         ALU_SLT: alu_result = word_t'($signed(alu_a) < $signed(alu_b));
         default: alu_result = '0;
      endcase
   end

   ////////////////////////////////////////
   // execute/complete register
   ////////////////////////////////////////

   // payload loads every edge
   always_ff @(posedge clock) begin
      ex_cm_tag    <= alu_tag;
      ex_cm_result <= alu_result;
      ex_cm_npc    <= alu_npc;
   end

   // valid follows the issue strobe by one cycle
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         ex_cm_valid <= 1'b0;
      end else begin
         ex_cm_valid <= alu_issue;
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   // the null tag is reserved for empty cdb slots
   a_issue_tag_not_null: assert property (
      @(posedge clock) disable iff (!rst_n)
      alu_issue |-> (alu_tag != RSTAG_NULL)
   ) else $error("alu_lane: issued tag is RSTAG_NULL");

   a_issue_op_known: assert property (
      @(posedge clock) disable iff (!rst_n)
      alu_issue |-> !$isunknown(alu_op)
   ) else $error("alu_lane: alu_op unknown at issue");

endmodule

//--- branch_lane.sv
////////////////////////////////////////
// branch resolution lane
// condition evaluation, next pc, link
// value, mispredict and its register
////////////////////////////////////////

`timescale 1ns/100ps

module branch_lane
   import ooo_pkg::*;
   import isa_pkg::*;
(
   input  logic       clock,
   input  logic       rst_n,

   // issue side
   input  logic       br_issue,
   input  rs_tag_t    br_tag,
   input  br_cond_t   br_cond,
   input  word_t      br_a,
   input  word_t      br_b,
   input  word_t      br_pc,
   input  word_t      br_offset,
   input  logic       br_pred_taken,
   input  pht_index_t br_pht_index,

   // to complete stage
   output rs_tag_t    ex_cm_tag,
   output word_t      ex_cm_result,
   output word_t      ex_cm_npc,
   output logic       ex_cm_mispredict,
   output br_result_t ex_cm_branch_result,
   output pht_index_t ex_cm_pht_index,
   output logic       ex_cm_valid
);

   logic       br_taken;
   word_t      link_pc;
   word_t      target_pc;
   word_t      next_pc;
   br_result_t br_result;

   ////////////////////////////////////////
   // resolve
   ////////////////////////////////////////

   always_comb begin
      case (br_cond)
         BR_EQ:     br_taken = (br_a == br_b);
         BR_NE:     br_taken = (br_a != br_b);
         BR_LT:     br_taken = ($signed(br_a) < $signed(br_b));
         BR_ALWAYS: br_taken = 1'b1;
         default:   br_taken = 1'b0;
      endcase
   end

   // fall-through doubles as the link value
   assign link_pc   = br_pc + word_t'(INSN_BYTES);
   assign target_pc = br_pc + br_offset;
   assign next_pc   = br_taken ? target_pc : link_pc;

   always_comb begin
      br_result = '0;
      br_result[BR_RESULT_IS_BRANCH] = 1'b1;
      br_result[BR_RESULT_TAKEN]     = br_taken;
   end

   ////////////////////////////////////////
   // execute/complete register
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      ex_cm_tag           <= br_tag;
      ex_cm_result        <= link_pc;
      ex_cm_npc           <= next_pc;
      ex_cm_branch_result <= br_result;
      ex_cm_pht_index     <= br_pht_index;
   end

   // mispredict only raised for an issued branch
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         ex_cm_valid      <= 1'b0;
         ex_cm_mispredict <= 1'b0;
      end else begin
         ex_cm_valid      <= br_issue;
         ex_cm_mispredict <= br_issue && (br_taken != br_pred_taken);
      end
   end

endmodule

//--- cm_stage.sv
////////////////////////////////////////
// complete stage
// packs both lane results onto the two
// cdb slots, lane 1 first
////////////////////////////////////////

`timescale 1ns/100ps

module cm_stage
   import ooo_pkg::*;
(
   // integer lane
   input  rs_tag_t    ex_cm_tag_1,
   input  word_t      ex_cm_result_1,
   input  word_t      ex_cm_npc_1,
   input  logic       ex_cm_mispredict_1,
   input  br_result_t ex_cm_branch_result_1,
   input  pht_index_t ex_cm_pht_index_1,
   input  logic       ex_cm_valid_1,

   // branch lane
   input  rs_tag_t    ex_cm_tag_2,
   input  word_t      ex_cm_result_2,
   input  word_t      ex_cm_npc_2,
   input  logic       ex_cm_mispredict_2,
   input  br_result_t ex_cm_branch_result_2,
   input  pht_index_t ex_cm_pht_index_2,
   input  logic       ex_cm_valid_2,

   // cdb slot 1
   output rs_tag_t    cdb_tag_1,
   output word_t      cdb_value_1,
   output word_t      cdb_npc_1,
   output logic       cdb_mispredict_1,
   output br_result_t cdb_branch_result_1,
   output pht_index_t cdb_pht_index_1,
   output logic       cdb_valid_1,

   // cdb slot 2
   output rs_tag_t    cdb_tag_2,
   output word_t      cdb_value_2,
   output word_t      cdb_npc_2,
   output logic       cdb_mispredict_2,
   output br_result_t cdb_branch_result_2,
   output pht_index_t cdb_pht_index_2,
   output logic       cdb_valid_2
);

   always_comb begin
      // empty slots by default
      cdb_tag_1           = RSTAG_NULL;
      cdb_value_1         = '0;
      cdb_npc_1           = '0;
      cdb_mispredict_1    = 1'b0;
      cdb_branch_result_1 = '0;
      cdb_pht_index_1     = '0;
      cdb_valid_1         = 1'b0;

      cdb_tag_2           = RSTAG_NULL;
      cdb_value_2         = '0;
      cdb_npc_2           = '0;
      cdb_mispredict_2    = 1'b0;
      cdb_branch_result_2 = '0;
      cdb_pht_index_2     = '0;
      cdb_valid_2         = 1'b0;

      if (ex_cm_valid_1) begin
         cdb_tag_1           = ex_cm_tag_1;
         cdb_value_1         = ex_cm_result_1;
         cdb_npc_1           = ex_cm_npc_1;
         cdb_mispredict_1    = ex_cm_mispredict_1;
         cdb_branch_result_1 = ex_cm_branch_result_1;
         cdb_pht_index_1     = ex_cm_pht_index_1;
         cdb_valid_1         = 1'b1;
      end

      // branch lane goes behind lane 1 or moves up to slot 1
      if (ex_cm_valid_2 && ex_cm_valid_1) begin
         cdb_tag_2           = ex_cm_tag_2;
         cdb_value_2         = ex_cm_result_2;
         cdb_npc_2           = ex_cm_npc_2;
         cdb_mispredict_2    = ex_cm_mispredict_2;
         cdb_branch_result_2 = ex_cm_branch_result_2;
         cdb_pht_index_2     = ex_cm_pht_index_2;
         cdb_valid_2         = 1'b1;
      end else if (ex_cm_valid_2) begin
         cdb_tag_1           = ex_cm_tag_2;
         cdb_value_1         = ex_cm_result_2;
         cdb_npc_1           = ex_cm_npc_2;
         cdb_mispredict_1    = ex_cm_mispredict_2;
         cdb_branch_result_1 = ex_cm_branch_result_2;
         cdb_pht_index_1     = ex_cm_pht_index_2;
         cdb_valid_1         = 1'b1;
      end

      // one rs entry cannot finish in both lanes
      if (ex_cm_valid_1 && ex_cm_valid_2) begin
         assert (ex_cm_tag_1 != ex_cm_tag_2)
            else $error("cm_stage: both lanes carry tag %h", ex_cm_tag_1);
      end
   end

endmodule

//--- complete_top.sv
////////////////////////////////////////
// execute and complete path
// integer lane, branch lane and the
// complete stage driving the cdb
////////////////////////////////////////

`timescale 1ns/100ps

module complete_top
   import ooo_pkg::*;
   import isa_pkg::*;
(
   input  logic       clock,
   input  logic       rst_n,

   // integer issue
   input  logic       alu_issue,
   input  rs_tag_t    alu_tag,
   input  alu_op_t    alu_op,
   input  word_t      alu_a,
   input  word_t      alu_b,
   input  word_t      alu_npc,

   // branch issue
   input  logic       br_issue,
   input  rs_tag_t    br_tag,
   input  br_cond_t   br_cond,
   input  word_t      br_a,
   input  word_t      br_b,
   input  word_t      br_pc,
   input  word_t      br_offset,
   input  logic       br_pred_taken,
   input  pht_index_t br_pht_index,

   // cdb
   output rs_tag_t    cdb_tag_1,
   output word_t      cdb_value_1,
   output word_t      cdb_npc_1,
   output logic       cdb_mispredict_1,
   output br_result_t cdb_branch_result_1,
   output pht_index_t cdb_pht_index_1,
   output logic       cdb_valid_1,
   output rs_tag_t    cdb_tag_2,
   output word_t      cdb_value_2,
   output word_t      cdb_npc_2,
   output logic       cdb_mispredict_2,
   output br_result_t cdb_branch_result_2,
   output pht_index_t cdb_pht_index_2,
   output logic       cdb_valid_2
);

   rs_tag_t    ex_cm_tag_1,           ex_cm_tag_2;
   word_t      ex_cm_result_1,        ex_cm_result_2;
   word_t      ex_cm_npc_1,           ex_cm_npc_2;
   logic       ex_cm_mispredict_1,    ex_cm_mispredict_2;
   br_result_t ex_cm_branch_result_1, ex_cm_branch_result_2;
   pht_index_t ex_cm_pht_index_1,     ex_cm_pht_index_2;
   logic       ex_cm_valid_1,         ex_cm_valid_2;

   // integer lane has no branch fields
   assign ex_cm_mispredict_1    = 1'b0;
   assign ex_cm_branch_result_1 = '0;
   assign ex_cm_pht_index_1     = '0;

   alu_lane u_alu_lane (
      .clock, .rst_n,
      .alu_issue, .alu_tag, .alu_op, .alu_a, .alu_b, .alu_npc,
      .ex_cm_tag    (ex_cm_tag_1),
      .ex_cm_result (ex_cm_result_1),
      .ex_cm_npc    (ex_cm_npc_1),
      .ex_cm_valid  (ex_cm_valid_1)
   );

   branch_lane u_branch_lane (
      .clock, .rst_n,
      .br_issue, .br_tag, .br_cond, .br_a, .br_b,
      .br_pc, .br_offset, .br_pred_taken, .br_pht_index,
      .ex_cm_tag           (ex_cm_tag_2),
      .ex_cm_result        (ex_cm_result_2),
      .ex_cm_npc           (ex_cm_npc_2),
      .ex_cm_mispredict    (ex_cm_mispredict_2),
      .ex_cm_branch_result (ex_cm_branch_result_2),
      .ex_cm_pht_index     (ex_cm_pht_index_2),
      .ex_cm_valid         (ex_cm_valid_2)
   );

   cm_stage u_cm_stage (.*);

endmodule

//--- complete_tb.sv
////////////////////////////////////////
// testbench for the execute/complete path
// random issue, reference model, cdb
// checks and coverage flags
////////////////////////////////////////

`timescale 1ns/100ps

module complete_tb
   import ooo_pkg::*;
   import isa_pkg::*;
();

   localparam int NUM_CYCLES    = 2000;
   localparam int RESET_TIMEOUT = 10;

   logic       clock;
   logic       rst_n;
   logic       alu_issue, br_issue, br_pred_taken;
   rs_tag_t    alu_tag, br_tag;
   alu_op_t    alu_op;
   br_cond_t   br_cond;
   word_t      alu_a, alu_b, alu_npc, br_a, br_b, br_pc, br_offset;
   pht_index_t br_pht_index;

   rs_tag_t    cdb_tag_1, cdb_tag_2;
   word_t      cdb_value_1, cdb_value_2, cdb_npc_1, cdb_npc_2;
   logic       cdb_mispredict_1, cdb_mispredict_2, cdb_valid_1, cdb_valid_2;
   br_result_t cdb_branch_result_1, cdb_branch_result_2;
   pht_index_t cdb_pht_index_1, cdb_pht_index_2;

   // expected contents of each slot
   logic       exp_valid [1:2];
   rs_tag_t    exp_tag [1:2];
   word_t      exp_value [1:2];
   word_t      exp_npc [1:2];
   logic       exp_mispredict [1:2];
   br_result_t exp_branch_result [1:2];
   pht_index_t exp_pht_index [1:2];

   // coverage flags
   logic [7:0] op_seen;
   logic [3:0] cond_seen;
   logic       taken_seen, fall_seen, mispredict_seen, only_br_seen;
   logic       both_seen, back_to_back_seen, idle_after_busy_seen;
   logic       prev_busy, prev_both;

   integer     seed;

   complete_top dut (.*);

   always #4 clock = ~clock;

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
      case (op)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_AND: return a & b;
         ALU_OR:  return a | b;
         ALU_XOR: return a ^ b;
         ALU_SLL: return a << b[5:0];
         ALU_SRL: return a >> b[5:0];
         ALU_SLT: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
         default: return '0;
      endcase
   endfunction

   function automatic logic cond_holds(input br_cond_t c, input word_t a, input word_t b);
      case (c)
         BR_EQ:   return a == b;
         BR_NE:   return a != b;
         BR_LT:   return $signed(a) < $signed(b);
         default: return 1'b1;
      endcase
   endfunction

   // empty slot masks every field
   task automatic set_slot(input int s, input logic v, input rs_tag_t tag, input word_t value,
                           input word_t npc, input logic mis, input br_result_t res,
                           input pht_index_t pht);
      exp_valid[s]         = v;
      exp_tag[s]           = v ? tag : RSTAG_NULL;
      exp_value[s]         = v ? value : '0;
      exp_npc[s]           = v ? npc : '0;
      exp_mispredict[s]    = v ? mis : 1'b0;
      exp_branch_result[s] = v ? res : 2'b00;
      exp_pht_index[s]     = v ? pht : '0;
   endtask

   // inputs seen at this edge show up on the cdb until the next edge
   always @(posedge clock or negedge rst_n) begin : model
      logic  taken;
      word_t link;
      word_t target;
      if (!rst_n) begin
         set_slot(1, 1'b0, RSTAG_NULL, '0, '0, 1'b0, 2'b00, '0);
         set_slot(2, 1'b0, RSTAG_NULL, '0, '0, 1'b0, 2'b00, '0);
         op_seen              = '0;
         cond_seen            = '0;
         taken_seen           = 1'b0;
         fall_seen            = 1'b0;
         mispredict_seen      = 1'b0;
         only_br_seen         = 1'b0;
         both_seen            = 1'b0;
         back_to_back_seen    = 1'b0;
         idle_after_busy_seen = 1'b0;
         prev_busy            = 1'b0;
         prev_both            = 1'b0;
      end else begin
         taken  = cond_holds(br_cond, br_a, br_b);
         link   = br_pc + 64'd4;
         target = taken ? br_pc + br_offset : link;
         if (alu_issue) begin
            set_slot(1, 1'b1, alu_tag, alu_model(alu_op, alu_a, alu_b), alu_npc,
                     1'b0, 2'b00, '0);
            set_slot(2, br_issue, br_tag, link, target, taken != br_pred_taken,
                     {1'b1, taken}, br_pht_index);
         end else begin
            // branch result moves up to slot 1
            set_slot(1, br_issue, br_tag, link, target, taken != br_pred_taken,
                     {1'b1, taken}, br_pht_index);
            set_slot(2, 1'b0, RSTAG_NULL, '0, '0, 1'b0, 2'b00, '0);
         end

         if (alu_issue)
            op_seen[alu_op] = 1'b1;
         if (br_issue) begin
            cond_seen[br_cond] = 1'b1;
            if (taken)
               taken_seen = 1'b1;
            else
               fall_seen = 1'b1;
            if (taken != br_pred_taken)
               mispredict_seen = 1'b1;
         end
         if (br_issue && !alu_issue)
            only_br_seen = 1'b1;
         if (br_issue && alu_issue) begin
            both_seen = 1'b1;
            if (prev_both)
               back_to_back_seen = 1'b1;
         end
         if (!alu_issue && !br_issue && prev_busy)
            idle_after_busy_seen = 1'b1;
         prev_busy = alu_issue || br_issue;
         prev_both = alu_issue && br_issue;
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
      $display("[ERROR] %s got %h expected %h", name, got, want);
      $display("Testbench failed");
      $fatal(1);
   endtask

   a_valid_1: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_valid_1 === exp_valid[1])
      else report_mismatch("cdb_valid_1", $sampled(cdb_valid_1), $sampled(exp_valid[1]));
   a_tag_1: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_tag_1 === exp_tag[1])
      else report_mismatch("cdb_tag_1", $sampled(cdb_tag_1), $sampled(exp_tag[1]));
   a_value_1: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_value_1 === exp_value[1])
      else report_mismatch("cdb_value_1", $sampled(cdb_value_1), $sampled(exp_value[1]));
   a_npc_1: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_npc_1 === exp_npc[1])
      else report_mismatch("cdb_npc_1", $sampled(cdb_npc_1), $sampled(exp_npc[1]));
   a_mispredict_1: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_mispredict_1 === exp_mispredict[1])
      else report_mismatch("cdb_mispredict_1", $sampled(cdb_mispredict_1),
                           $sampled(exp_mispredict[1]));
   a_branch_result_1: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_branch_result_1 === exp_branch_result[1])
      else report_mismatch("cdb_branch_result_1", $sampled(cdb_branch_result_1),
                           $sampled(exp_branch_result[1]));
   a_pht_index_1: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_pht_index_1 === exp_pht_index[1])
      else report_mismatch("cdb_pht_index_1", $sampled(cdb_pht_index_1),
                           $sampled(exp_pht_index[1]));

   a_valid_2: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_valid_2 === exp_valid[2])
      else report_mismatch("cdb_valid_2", $sampled(cdb_valid_2), $sampled(exp_valid[2]));
   a_tag_2: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_tag_2 === exp_tag[2])
      else report_mismatch("cdb_tag_2", $sampled(cdb_tag_2), $sampled(exp_tag[2]));
   a_value_2: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_value_2 === exp_value[2])
      else report_mismatch("cdb_value_2", $sampled(cdb_value_2), $sampled(exp_value[2]));
   a_npc_2: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_npc_2 === exp_npc[2])
      else report_mismatch("cdb_npc_2", $sampled(cdb_npc_2), $sampled(exp_npc[2]));
   a_mispredict_2: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_mispredict_2 === exp_mispredict[2])
      else report_mismatch("cdb_mispredict_2", $sampled(cdb_mispredict_2),
                           $sampled(exp_mispredict[2]));
   a_branch_result_2: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_branch_result_2 === exp_branch_result[2])
      else report_mismatch("cdb_branch_result_2", $sampled(cdb_branch_result_2),
                           $sampled(exp_branch_result[2]));
   a_pht_index_2: assert property (@(posedge clock) disable iff (!rst_n)
      cdb_pht_index_2 === exp_pht_index[2])
      else report_mismatch("cdb_pht_index_2", $sampled(cdb_pht_index_2),
                           $sampled(exp_pht_index[2]));

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   task automatic drive_idle;
      alu_issue     = 1'b0;
      alu_tag       = '0;
      alu_op        = ALU_ADD;
      alu_a         = '0;
      alu_b         = '0;
      alu_npc       = '0;
      br_issue      = 1'b0;
      br_tag        = '0;
      br_cond       = BR_EQ;
      br_a          = '0;
      br_b          = '0;
      br_pc         = '0;
      br_offset     = '0;
      br_pred_taken = 1'b0;
      br_pht_index  = '0;
   endtask

   // tags 0..14 for the integer lane, 15..29 for the branch lane
   task automatic drive_random;
      alu_issue     = $random(seed) & 1;
      alu_tag       = rs_tag_t'({$random(seed)} % 15);
      alu_op        = alu_op_t'($random(seed));
      alu_a         = {$random(seed), $random(seed)};
      alu_b         = {$random(seed), $random(seed)};
      alu_npc       = {$random(seed), $random(seed)};
      br_issue      = $random(seed) & 1;
      br_tag        = rs_tag_t'(15 + {$random(seed)} % 15);
      br_cond       = br_cond_t'($random(seed));
      br_a          = {$random(seed), $random(seed)};
      br_b          = ({$random(seed)} % 4 == 0) ? br_a : {$random(seed), $random(seed)};
      br_pc         = {$random(seed), $random(seed)};
      br_offset     = {$random(seed), $random(seed)};
      br_pred_taken = $random(seed) & 1;
      br_pht_index  = pht_index_t'($random(seed));
   endtask

   initial begin : stimulus
      integer cycle;
      integer wait_count;
      seed  = 7620;
      clock = 1'b0;
      rst_n = 1'b0;
      drive_idle;
      repeat (2) @(posedge clock);
      @(negedge clock);
      rst_n = 1'b1;

      // cdb must come out of reset empty
      wait_count = 0;
      while ((cdb_valid_1 || cdb_valid_2) && wait_count < RESET_TIMEOUT) begin
         @(negedge clock);
         wait_count++;
      end
      if (cdb_valid_1 || cdb_valid_2) begin
         $display("timeout waiting for an empty cdb after reset");
         $display("Testbench failed");
         $fatal(1);
      end
      repeat (3) @(negedge clock);

      for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
         drive_random;
         @(negedge clock);
      end
      drive_idle;
      repeat (3) @(negedge clock);

      if (!(&op_seen) || !(&cond_seen) || !taken_seen || !fall_seen || !mispredict_seen ||
          !only_br_seen || !both_seen || !back_to_back_seen || !idle_after_busy_seen) begin
         $display("coverage incomplete, some issue case never occurred");
         $display("Testbench failed");
         $fatal(1);
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

//--- verilog.f
ooo_pkg.sv
isa_pkg.sv
alu_lane.sv
branch_lane.sv
cm_stage.sv
complete_top.sv
complete_tb.sv

//--- Bender.yml
package:
  name: complete_path

sources:
  - files:
      - ooo_pkg.sv
      - isa_pkg.sv
      - alu_lane.sv
      - branch_lane.sv
      - cm_stage.sv
      - complete_top.sv
  - target: simulation
    files:
      - complete_tb.sv
